// File: Makefile
VERILATOR   ?= verilator
TOP         ?= mips_decode_exec_tb
FILELIST    ?= mips_decode_exec.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert
PASS_TEXT   ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpu_types_pkg.sv
package cpu_types_pkg;

    // widths fixed by the instruction set
    parameter int WORD_W   = 32;
    parameter int REG_W    = 5;
    parameter int IMM_W    = 16;
    parameter int JADDR_W  = 26;
    parameter int OP_W     = 6;
    parameter int FUNCT_W  = 6;
    parameter int ALUOP_W  = 4;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [REG_W-1:0]   regbits_t;
    typedef logic [IMM_W-1:0]   imm_t;
    typedef logic [JADDR_W-1:0] jaddr_t;
    typedef logic [REG_W-1:0]   shamt_t;

    // primary opcode field, bits 31:26
    typedef enum logic [OP_W-1:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        ADDIU = 6'h09,
        SLTI  = 6'h0A,
        SLTIU = 6'h0B,
        ANDI  = 6'h0C,
        ORI   = 6'h0D,
        XORI  = 6'h0E,
        LUI   = 6'h0F,
        LW    = 6'h23,
        SW    = 6'h2B,
        HALT  = 6'h3F
    } opcode_t;

    // function field of R-type, bits 5:0
    typedef enum logic [FUNCT_W-1:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        JR   = 6'h08,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2A,
        SLTU = 6'h2B
    } funct_t;

    typedef enum logic [ALUOP_W-1:0] {
        ALU_SLL,
        ALU_SRL,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU
    } aluop_t;

    // everything crossing the ID/EX boundary
    typedef struct packed {
        word_t    instr;
        word_t    pc;
        word_t    pcplusfour;
        word_t    rdat1;
        word_t    rdat2;
        word_t    ext_imm;
        regbits_t reg_rs;
        regbits_t reg_rt;
        regbits_t reg_rd;
        shamt_t   shamt;
        jaddr_t   j_addr;
        opcode_t  opcode;
        funct_t   funct;
        aluop_t   aluctr;
        // single-bit controls
        logic     alusrc;
        logic     regdst;
        logic     regwr;
        logic     memwr;
        logic     memtoreg;
        logic     dren;
        logic     dwen;
        logic     beq_s;
        logic     bne_s;
        logic     jump_s;
        logic     jr_s;
        logic     jal_s;
        logic     lui;
        logic     halt;
    } de_ex_t;

    // bubble loaded on reset
    parameter de_ex_t NOP_DE_EX = '0;

endpackage

// File: idecode_iexec.sv
`timescale 1ns/1ns

module idecode_iexec import cpu_types_pkg::*; (
    input  logic   CLK,
    input  logic   nRST,
    input  de_ex_t de_next,
    output de_ex_t de_q
);

    // ID/EX latch
    // no stall or flush, loads every edge
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // bubble: all controls low
            de_q <= NOP_DE_EX;
        end else begin
            de_q <= de_next;
        end
    end

endmodule

// File: instr_decode.sv
`timescale 1ns/1ns

module instr_decode import cpu_types_pkg::*; (
    input  word_t    instr,
    input  word_t    pc,
    output regbits_t rsel1,
    output regbits_t rsel2,
    input  word_t    rdat1,
    input  word_t    rdat2,
    output de_ex_t   de_next
);

    opcode_t op;
    funct_t  fn;
    imm_t    imm;
    logic    zero_ext;
    logic    r_alu;

    // instruction fields
    assign op  = opcode_t'(instr[31:26]);
    assign fn  = funct_t'(instr[5:0]);
    assign imm = instr[15:0];

    // register file addressed straight from rs and rt
    assign rsel1 = instr[25:21];
    assign rsel2 = instr[20:16];

    // logical immediates zero-extend
    assign zero_ext = (op == ANDI) || (op == ORI) || (op == XORI);

    always_comb begin
        // start from a bubble, controls all low
        de_next = NOP_DE_EX;
        r_alu   = 1'b0;

        de_next.instr      = instr;
        de_next.pc         = pc;
        de_next.pcplusfour = pc + 32'd4;
        de_next.rdat1      = rdat1;
        de_next.rdat2      = rdat2;
        de_next.reg_rs     = instr[25:21];
        de_next.reg_rt     = instr[20:16];
        de_next.reg_rd     = instr[15:11];
        de_next.shamt      = instr[10:6];
        de_next.j_addr     = instr[25:0];
        de_next.opcode     = op;
        de_next.funct      = fn;
        de_next.ext_imm    = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

        case (op)
            RTYPE: begin
                r_alu = 1'b1;
                case (fn)
                    SLL:       de_next.aluctr = ALU_SLL;
                    SRL:       de_next.aluctr = ALU_SRL;
                    ADD, ADDU: de_next.aluctr = ALU_ADD;
                    SUB, SUBU: de_next.aluctr = ALU_SUB;
                    AND:       de_next.aluctr = ALU_AND;
                    OR:        de_next.aluctr = ALU_OR;
                    XOR:       de_next.aluctr = ALU_XOR;
                    NOR:       de_next.aluctr = ALU_NOR;
                    SLT:       de_next.aluctr = ALU_SLT;
                    SLTU:      de_next.aluctr = ALU_SLTU;
                    JR: begin
                        // register jump, nothing written back
                        r_alu         = 1'b0;
                        de_next.jr_s  = 1'b1;
                    end
                    // unknown funct stays a bubble
                    default:   r_alu = 1'b0;
                endcase
                de_next.regdst = r_alu;
                de_next.regwr  = r_alu;
            end
            ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI: begin
                de_next.alusrc = 1'b1;
                de_next.regwr  = 1'b1;
                case (op)
                    SLTI:    de_next.aluctr = ALU_SLT;
                    SLTIU:   de_next.aluctr = ALU_SLTU;
                    ANDI:    de_next.aluctr = ALU_AND;
                    ORI:     de_next.aluctr = ALU_OR;
                    XORI:    de_next.aluctr = ALU_XOR;
                    default: de_next.aluctr = ALU_ADD;
                endcase
            end
            LUI: begin
                de_next.alusrc = 1'b1;
                de_next.regwr  = 1'b1;
                de_next.lui    = 1'b1;
            end
            LW: begin
                // address = rs + imm
                de_next.alusrc   = 1'b1;
                de_next.aluctr   = ALU_ADD;
                de_next.regwr    = 1'b1;
                de_next.memtoreg = 1'b1;
                de_next.dren     = 1'b1;
            end
            SW: begin
                de_next.alusrc = 1'b1;
                de_next.aluctr = ALU_ADD;
                de_next.memwr  = 1'b1;
                de_next.dwen   = 1'b1;
            end
            BEQ: begin
                de_next.aluctr = ALU_SUB;
                de_next.beq_s  = 1'b1;
            end
            BNE: begin
                de_next.aluctr = ALU_SUB;
                de_next.bne_s  = 1'b1;
            end
            J:   de_next.jump_s = 1'b1;
            JAL: begin
                // link into $ra
                de_next.jump_s = 1'b1;
                de_next.jal_s  = 1'b1;
                de_next.regwr  = 1'b1;
            end
            HALT:    de_next.halt = 1'b1;
            default: de_next.halt = 1'b0;
        endcase
    end

endmodule

// File: instr_exec.sv
`timescale 1ns/1ns

module instr_exec import cpu_types_pkg::*; (
    input  de_ex_t   de_q,
    output word_t    ex_result,
    output word_t    ex_store_data,
    output regbits_t ex_dest,
    output logic     ex_regwr,
    output logic     ex_dren,
    output logic     ex_dwen,
    output logic     ex_memtoreg,
    output logic     branch_taken,
    output word_t    branch_target,
    output logic     jump_taken,
    output logic     halt
);

    word_t opa;
    word_t opb;
    word_t alu_out;
    word_t jump_target;
    word_t br_offset;
    logic  ops_equal;

    // second operand: immediate or rt
    assign opa = de_q.rdat1;
    assign opb = de_q.alusrc ? de_q.ext_imm : de_q.rdat2;

    always_comb begin
        case (de_q.aluctr)
            // shifts act on rt by shamt
            ALU_SLL:  alu_out = opb << de_q.shamt;
            ALU_SRL:  alu_out = opb >> de_q.shamt;
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_NOR:  alu_out = ~(opa | opb);
            ALU_SLT:  alu_out = {31'd0, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {31'd0, opa < opb};
            default:  alu_out = '0;
        endcase
    end

    // result mux: link address, upper immediate, else ALU
    // loads and stores get their address from the ALU add
    always_comb begin
        if (de_q.jal_s) begin
            ex_result = de_q.pcplusfour;
        end else if (de_q.lui) begin
            ex_result = {de_q.ext_imm[15:0], 16'h0000};
        end else begin
            ex_result = alu_out;
        end
    end

    // destination: $ra for jal, rd for R-type, rt otherwise
    always_comb begin
        if (de_q.jal_s) begin
            ex_dest = 5'd31;
        end else if (de_q.regdst) begin
            ex_dest = de_q.reg_rd;
        end else begin
            ex_dest = de_q.reg_rt;
        end
    end

    assign ex_store_data = de_q.rdat2;
    assign ex_regwr      = de_q.regwr;
    assign ex_dren       = de_q.dren;
    assign ex_dwen       = de_q.dwen;
    assign ex_memtoreg   = de_q.memtoreg;
    assign halt          = de_q.halt;

    // branch resolution
    assign ops_equal    = (de_q.rdat1 == de_q.rdat2);
    assign branch_taken = (de_q.beq_s & ops_equal) | (de_q.bne_s & ~ops_equal);
    assign br_offset    = de_q.ext_imm << 2;

    // jr uses rs, j/jal use pseudo-direct address
    assign jump_taken  = de_q.jump_s | de_q.jr_s;
    assign jump_target = de_q.jr_s ? de_q.rdat1
                                   : {de_q.pcplusfour[31:28], de_q.j_addr, 2'b00};

    // one target bus shared by branches and jumps
    assign branch_target = jump_taken ? jump_target : de_q.pcplusfour + br_offset;

endmodule

// File: mips_decode_exec.f
cpu_types_pkg.sv
register_file.sv
instr_decode.sv
idecode_iexec.sv
instr_exec.sv
mips_decode_exec.sv
mips_decode_exec_properties.sv
mips_decode_exec_tb.sv

// File: mips_decode_exec.sv
`timescale 1ns/1ns

module mips_decode_exec import cpu_types_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  word_t    instr,
    input  word_t    pc,
    // writeback port into the register file
    input  logic     wb_en,
    input  regbits_t wb_sel,
    input  word_t    wb_data,
    output word_t    ex_result,
    output word_t    ex_store_data,
    output regbits_t ex_dest,
    output logic     ex_regwr,
    output logic     ex_dren,
    output logic     ex_dwen,
    output logic     ex_memtoreg,
    output logic     branch_taken,
    output word_t    branch_target,
    output logic     jump_taken,
    output logic     halt
);

    regbits_t rsel1;
    regbits_t rsel2;
    word_t    rdat1;
    word_t    rdat2;
    de_ex_t   de_next;
    de_ex_t   de_q;

    register_file register_file_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb_en),
        .wsel  (wb_sel),
        .wdat  (wb_data),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    // decode stage, combinational
    instr_decode instr_decode_i (
        .instr   (instr),
        .pc      (pc),
        .rsel1   (rsel1),
        .rsel2   (rsel2),
        .rdat1   (rdat1),
        .rdat2   (rdat2),
        .de_next (de_next)
    );

    // the only clocked stage boundary
    idecode_iexec idecode_iexec_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .de_next (de_next),
        .de_q    (de_q)
    );

    instr_exec instr_exec_i (
        .de_q          (de_q),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_dest       (ex_dest),
        .ex_regwr      (ex_regwr),
        .ex_dren       (ex_dren),
        .ex_dwen       (ex_dwen),
        .ex_memtoreg   (ex_memtoreg),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .jump_taken    (jump_taken),
        .halt          (halt)
    );

endmodule

// File: mips_decode_exec_properties.sv
`timescale 1ns/1ns

module mips_decode_exec_properties import cpu_types_pkg::*; (
    input logic     CLK,
    input logic     nRST,
    input word_t    instr,
    input word_t    pc,
    input logic     wb_en,
    input regbits_t wb_sel,
    input word_t    wb_data,
    input word_t    ex_result,
    input word_t    ex_store_data,
    input regbits_t ex_dest,
    input logic     ex_regwr,
    input logic     ex_dren,
    input logic     ex_dwen,
    input logic     ex_memtoreg,
    input logic     branch_taken,
    input word_t    branch_target,
    input logic     jump_taken,
    input logic     halt
);

    // shadow copy of the register file, $zero never written
    word_t       shadow [32];
    word_t       prev_instr;
    word_t       prev_pc;
    word_t       prev_a;
    word_t       prev_b;
    logic        prev_valid;
    int unsigned result_errs = 0;
    int unsigned ctrl_errs = 0;
    int unsigned flow_errs = 0;

    opcode_t     op;
    funct_t      fn;
    word_t       sext;
    word_t       pc4;
    word_t       exp_res;
    word_t       exp_tgt;
    regbits_t    exp_dest;
    logic        has_res;
    logic        exp_regwr;
    logic        exp_br;
    logic        exp_jump;
    logic [4:0]  exp_ctrl;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
            prev_instr <= '0;
            prev_pc    <= '0;
            prev_a     <= '0;
            prev_b     <= '0;
            prev_valid <= 1'b0;
        end else begin
            if (wb_en && (wb_sel != '0)) begin
                shadow[wb_sel] <= wb_data;
            end
            // operands as seen before this edge's write
            prev_instr <= instr;
            prev_pc    <= pc;
            prev_a     <= shadow[instr[25:21]];
            prev_b     <= shadow[instr[20:16]];
            prev_valid <= 1'b1;
        end
    end

    // expected outputs for the instruction in execute
    always_comb begin
        op        = opcode_t'(prev_instr[31:26]);
        fn        = funct_t'(prev_instr[5:0]);
        sext      = {{16{prev_instr[15]}}, prev_instr[15:0]};
        pc4       = prev_pc + 32'd4;
        exp_res   = prev_a + sext;
        exp_dest  = prev_instr[20:16];
        has_res   = 1'b1;
        exp_regwr = 1'b1;
        case (op)
            RTYPE: begin
                exp_dest = prev_instr[15:11];
                case (fn)
                    SLL:       exp_res = prev_b << prev_instr[10:6];
                    SRL:       exp_res = prev_b >> prev_instr[10:6];
                    ADD, ADDU: exp_res = prev_a + prev_b;
                    SUB, SUBU: exp_res = prev_a - prev_b;
                    AND:       exp_res = prev_a & prev_b;
                    OR:        exp_res = prev_a | prev_b;
                    XOR:       exp_res = prev_a ^ prev_b;
                    NOR:       exp_res = ~(prev_a | prev_b);
                    SLT:       exp_res = {31'd0, $signed(prev_a) < $signed(prev_b)};
                    SLTU:      exp_res = {31'd0, prev_a < prev_b};
                    // jr writes nothing
                    default: begin
                        has_res   = 1'b0;
                        exp_regwr = 1'b0;
                    end
                endcase
            end
            ADDI, ADDIU, LW: exp_res = prev_a + sext;
            SW:    exp_regwr = 1'b0;
            SLTI:  exp_res = {31'd0, $signed(prev_a) < $signed(sext)};
            SLTIU: exp_res = {31'd0, prev_a < sext};
            // logical immediates are zero-extended
            ANDI:  exp_res = prev_a & {16'h0000, prev_instr[15:0]};
            ORI:   exp_res = prev_a | {16'h0000, prev_instr[15:0]};
            XORI:  exp_res = prev_a ^ {16'h0000, prev_instr[15:0]};
            LUI:   exp_res = {prev_instr[15:0], 16'h0000};
            JAL: begin
                exp_res  = pc4;
                exp_dest = 5'd31;
            end
            default: begin
                has_res   = 1'b0;
                exp_regwr = 1'b0;
            end
        endcase
        exp_ctrl = {exp_regwr, op == LW, op == SW, op == LW, op == HALT};
        exp_br   = ((op == BEQ) && (prev_a == prev_b)) || ((op == BNE) && (prev_a != prev_b));
        exp_jump = (op == J) || (op == JAL) || ((op == RTYPE) && (fn == JR));
        if (exp_jump) begin
            exp_tgt = ((op == RTYPE) ? prev_a : {pc4[31:28], prev_instr[25:0], 2'b00});
        end else begin
            exp_tgt = pc4 + (sext << 2);
        end
    end

    // bubble during reset and on the first edge after it
    assert property (@(posedge CLK)
        !prev_valid |-> !(ex_regwr | ex_dren | ex_dwen | branch_taken | jump_taken | halt))
    else begin
        ctrl_errs++;
        $error("controls were not all low coming out of reset");
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        prev_valid && has_res |-> ex_result == exp_res)
    else begin
        result_errs++;
        $error("Error ex_result got %h expected %h", $sampled(ex_result), $sampled(exp_res));
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        prev_valid && exp_regwr |-> ex_dest == exp_dest)
    else begin
        result_errs++;
        $error("Error ex_dest got %h expected %h", $sampled(ex_dest), $sampled(exp_dest));
    end

    // regwr, dren, dwen, memtoreg, halt
    assert property (@(posedge CLK) disable iff (!nRST)
        prev_valid |-> {ex_regwr, ex_dren, ex_dwen, ex_memtoreg, halt} == exp_ctrl)
    else begin
        ctrl_errs++;
        $error("Error controls got %h expected %h",
            $sampled({ex_regwr, ex_dren, ex_dwen, ex_memtoreg, halt}), $sampled(exp_ctrl));
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        prev_valid && (op == SW) |-> ex_store_data == prev_b)
    else begin
        result_errs++;
        $error("Error ex_store_data got %h expected %h",
            $sampled(ex_store_data), $sampled(prev_b));
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        prev_valid |-> {branch_taken, jump_taken} == {exp_br, exp_jump})
    else begin
        flow_errs++;
        $error("Error branch_taken/jump_taken got %h expected %h",
            $sampled({branch_taken, jump_taken}), $sampled({exp_br, exp_jump}));
    end

    // target only matters when control flow changes
    assert property (@(posedge CLK) disable iff (!nRST)
        prev_valid && (exp_br || exp_jump) |-> branch_target == exp_tgt)
    else begin
        flow_errs++;
        $error("Error branch_target got %h expected %h",
            $sampled(branch_target), $sampled(exp_tgt));
    end

endmodule

// File: mips_decode_exec_tb.sv
`timescale 1ns/1ns

module mips_decode_exec_tb import cpu_types_pkg::*; ();

    logic     CLK;
    logic     nRST;
    word_t    instr;
    word_t    pc;
    logic     wb_en;
    regbits_t wb_sel;
    word_t    wb_data;
    word_t    ex_result;
    word_t    ex_store_data;
    regbits_t ex_dest;
    logic     ex_regwr;
    logic     ex_dren;
    logic     ex_dwen;
    logic     ex_memtoreg;
    logic     branch_taken;
    word_t    branch_target;
    logic     jump_taken;
    logic     halt;

    word_t       lcg_state;
    int unsigned timeouts;
    int unsigned total_errs;

    // opcodes and functs for the random mix
    opcode_t op_list [15] = '{RTYPE, J, JAL, BEQ, BNE, ADDI, ADDIU, SLTI, SLTIU,
                              ANDI, ORI, XORI, LUI, LW, SW};
    funct_t  fn_list [13] = '{SLL, SRL, JR, ADD, ADDU, SUB, SUBU, AND, OR, XOR,
                              NOR, SLT, SLTU};

    mips_decode_exec mips_decode_exec_i (.*);

    // checker with its own shadow register file
    bind mips_decode_exec mips_decode_exec_properties properties_i (.*);

    always #20 CLK = ~CLK;

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rs, rt and the low fields come straight from the random bits
    function automatic word_t make_instr(opcode_t op, funct_t fn, word_t bits);
        if (op == RTYPE) begin
            return {6'h00, bits[25:6], fn};
        end
        return {op, bits[25:0]};
    endfunction

    // one instruction per cycle, word aligned pc
    task automatic apply(word_t i);
        instr = i;
        pc    = next_random() & 32'hFFFF_FFFC;
        @(posedge CLK);
        #5;
    endtask

    task automatic write_reg(regbits_t sel, word_t data);
        wb_en   = 1'b1;
        wb_sel  = sel;
        wb_data = data;
        @(posedge CLK);
        #5;
        wb_en = 1'b0;
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        while (!halt && (n < 8)) begin
            @(posedge CLK);
            #5;
            n++;
        end
        if (!halt) begin
            timeouts++;
            $display("timeout: halt output never rose after the halt opcode");
        end
    endtask

    initial begin
        word_t r;
        CLK       = 1'b0;
        nRST      = 1'b1;
        instr     = '0;
        pc        = '0;
        wb_en     = 1'b0;
        wb_sel    = '0;
        wb_data   = '0;
        lcg_state = 32'h985b_09d0;
        timeouts  = 0;
        #1;
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        #5;
        nRST = 1'b1;

        // fill every register, $zero too
        for (int i = 0; i < 32; i++) begin
            write_reg(regbits_t'(i), next_random());
        end

        // every R-type function, then every other opcode
        for (int i = 0; i < 13; i++) begin
            apply(make_instr(RTYPE, fn_list[i], next_random()));
        end
        for (int i = 1; i < 15; i++) begin
            apply(make_instr(op_list[i], SLL, next_random()));
        end

        // $zero operands and branches on equal registers
        apply({6'h00, 5'd0, 5'd0, 5'd7, 5'd0, ADD});
        apply({BEQ, 5'd9, 5'd9, 16'hFFF0});
        apply({BNE, 5'd9, 5'd9, 16'h0010});
        apply({BEQ, 5'd0, 5'd0, 16'h0004});

        // random mix, writebacks landing alongside
        for (int k = 0; k < 300; k++) begin
            r       = next_random();
            wb_en   = r[31];
            wb_sel  = r[4:0];
            wb_data = next_random();
            apply(make_instr(op_list[r[15:8] % 15], fn_list[r[23:16] % 13], next_random()));
        end
        wb_en = 1'b0;

        instr = {HALT, 26'd0};
        pc    = next_random() & 32'hFFFF_FFFC;
        wait_for_halt();
        apply(32'h0000_0000);
        apply(32'h0000_0000);

        total_errs = mips_decode_exec_i.properties_i.result_errs
                   + mips_decode_exec_i.properties_i.ctrl_errs
                   + mips_decode_exec_i.properties_i.flow_errs
                   + timeouts;
        $display("result errors %0d, control errors %0d, branch/jump errors %0d, timeouts %0d",
            mips_decode_exec_i.properties_i.result_errs,
            mips_decode_exec_i.properties_i.ctrl_errs,
            mips_decode_exec_i.properties_i.flow_errs,
            timeouts);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ns

module register_file import cpu_types_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wen,
    input  regbits_t wsel,
    input  word_t    wdat,
    input  regbits_t rsel1,
    input  regbits_t rsel2,
    output word_t    rdat1,
    output word_t    rdat2
);

    // 32 general purpose registers
    word_t regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // whole array cleared on reset
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            // writes to $zero dropped
            regs[wsel] <= wdat;
        end
    end

    // combinational reads, no bypass of same-edge write
    always_comb begin
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else begin
            rdat1 = regs[rsel1];
        end
    end

    always_comb begin
        if (rsel2 == '0) begin
            rdat2 = '0;
        end else begin
            rdat2 = regs[rsel2];
        end
    end

endmodule
